// File: common/bmm_cfg_pkg.sv
package bmm_cfg_pkg;

  // ##########################################################################
  // sizes
  // ##########################################################################
  parameter int NUM_VBANKS = 4;
  parameter int NUM_PBANKS = NUM_VBANKS + 1;  // one spare bank
  parameter int ROWS       = 16;
  parameter int DATA_W     = 32;

  localparam int VB_W  = $clog2(NUM_VBANKS);
  localparam int PB_W  = $clog2(NUM_PBANKS);
  localparam int ROW_W = $clog2(ROWS);

  typedef logic [VB_W-1:0]   vbank_t;
  typedef logic [PB_W-1:0]   pbank_t;
  typedef logic [ROW_W-1:0]  row_t;
  typedef logic [DATA_W-1:0] data_t;

  // ##########################################################################
  // address and command structs
  // ##########################################################################
  typedef struct packed {
    vbank_t bank;
    row_t   row;
  } vaddr_t;

  typedef struct packed {
    logic   read;
    logic   write;
    vaddr_t rd_addr;
    vaddr_t wr_addr;
    data_t  wr_data;
  } vreq_t;

  typedef struct packed {
    logic   en;
    pbank_t bank;
    row_t   row;
  } pcmd_t;

endpackage

// File: common/bmm_map_pkg.sv
package bmm_map_pkg;

  import bmm_cfg_pkg::*;

  // field v holds the physical bank of virtual bank v, top field is free
  typedef pbank_t [NUM_PBANKS-1:0] map_entry_t;

  localparam int FREE_IDX = NUM_VBANKS;

  typedef struct packed {
    logic       en;
    row_t       row;
    map_entry_t entry;
  } map_wr_t;

  typedef enum logic {
    ST_INIT,  // identity sweep over all rows
    ST_RUN
  } ctrl_state_e;

endpackage

// File: design/req_pipe.sv
module req_pipe #(
  parameter int SRAM_DELAY = 2,
  parameter int FLOPIN     = 0
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                ready,
  input  logic                wr_en,
  input  bmm_cfg_pkg::vaddr_t wr_addr,
  input  bmm_cfg_pkg::data_t  wr_data,
  input  logic                rd_en,
  input  bmm_cfg_pkg::vaddr_t rd_addr,
  output bmm_cfg_pkg::vreq_t  now_req,
  output bmm_cfg_pkg::vreq_t  due_req
);

  import bmm_cfg_pkg::*;

  vreq_t in_req;
  vreq_t dly [SRAM_DELAY];

  always_comb begin
    in_req.read    = rd_en && ready;  // dropped until init is done
    in_req.write   = wr_en && ready;
    in_req.rd_addr = rd_addr;
    in_req.wr_addr = wr_addr;
    in_req.wr_data = wr_data;
  end

  // ##########################################################################
  // optional input stage
  // ##########################################################################
  if (FLOPIN != 0) begin : g_flopin
    always_ff @(posedge clk) begin
      now_req <= in_req;
      if (rst) begin
        now_req.read  <= 1'b0;
        now_req.write <= 1'b0;
      end
    end
  end else begin : g_direct
    assign now_req = in_req;
  end

  // ##########################################################################
  // delay line matching the map lookup
  // ##########################################################################
  always_ff @(posedge clk) begin
    dly[0] <= now_req;
    for (int i = 1; i < SRAM_DELAY; i++) begin
      dly[i] <= dly[i-1];
    end
    if (rst) begin
      for (int i = 0; i < SRAM_DELAY; i++) begin
        dly[i].read  <= 1'b0;
        dly[i].write <= 1'b0;
      end
    end
  end

  assign due_req = dly[SRAM_DELAY-1];

endmodule

// File: remap/map_table.sv
module map_table #(
  parameter int SRAM_DELAY = 2
) (
  input  logic                     clk,
  input  logic                     rst,
  input  bmm_cfg_pkg::row_t        wr_row,
  input  bmm_cfg_pkg::row_t        rd_row,
  input  logic                     lookup_wr,
  input  logic                     lookup_rd,
  input  bmm_map_pkg::map_wr_t     upd,
  output bmm_map_pkg::map_entry_t  wr_entry,
  output bmm_map_pkg::map_entry_t  rd_entry
);

  import bmm_cfg_pkg::*;
  import bmm_map_pkg::*;

  localparam int NP = 2;  // port 0 write lookup, port 1 read lookup

  map_entry_t mem [ROWS];
  row_t       look_row [NP];
  logic       look_en [NP];
  logic       vld [NP][SRAM_DELAY];
  row_t       srow [NP][SRAM_DELAY];
  logic       fwd [NP][SRAM_DELAY];
  map_entry_t fent [NP][SRAM_DELAY];
  map_entry_t sdat [NP][SRAM_DELAY];
  map_entry_t entry_out [NP];

  function automatic logic has_dup(map_entry_t e);
    logic dup;
    dup = 1'b0;
    for (int a = 0; a < NUM_PBANKS; a++) begin
      for (int b = a + 1; b < NUM_PBANKS; b++) begin
        if (e[a] == e[b]) dup = 1'b1;
      end
    end
    return dup;
  endfunction

  always_comb begin
    look_row[0] = wr_row;
    look_row[1] = rd_row;
    look_en[0]  = lookup_wr;
    look_en[1]  = lookup_rd;
  end

  always_ff @(posedge clk) begin
    if (upd.en) mem[upd.row] <= upd.entry;
  end

  // ##########################################################################
  // lookup pipe with update forwarding
  // ##########################################################################
  always_ff @(posedge clk) begin
    for (int p = 0; p < NP; p++) begin
      if (look_en[p] && !(upd.en && (upd.row == look_row[p]))) begin
        sdat[p][0] <= mem[look_row[p]];  // skipped when forwarded
      end
      vld[p][0]  <= look_en[p];
      srow[p][0] <= look_row[p];
      fwd[p][0]  <= upd.en && (upd.row == look_row[p]);
      fent[p][0] <= upd.entry;
      for (int i = 1; i < SRAM_DELAY; i++) begin
        vld[p][i]  <= vld[p][i-1];
        srow[p][i] <= srow[p][i-1];
        sdat[p][i] <= sdat[p][i-1];
        if (upd.en && (upd.row == srow[p][i-1])) begin
          fwd[p][i]  <= 1'b1;  // newest update wins
          fent[p][i] <= upd.entry;
        end else begin
          fwd[p][i]  <= fwd[p][i-1];
          fent[p][i] <= fent[p][i-1];
        end
      end
      if (rst) begin
        for (int i = 0; i < SRAM_DELAY; i++) begin
          vld[p][i] <= 1'b0;
          fwd[p][i] <= 1'b0;
        end
      end
    end
  end

  always_comb begin
    for (int p = 0; p < NP; p++) begin
      entry_out[p] = fwd[p][SRAM_DELAY-1] ? fent[p][SRAM_DELAY-1] : sdat[p][SRAM_DELAY-1];
    end
  end

  assign wr_entry = entry_out[0];
  assign rd_entry = entry_out[1];

  for (genvar p = 0; p < NP; p++) begin : g_chk
    a_entry_perm: assert property (
      @(posedge clk) disable iff (rst)
      vld[p][SRAM_DELAY-1] |-> !has_dup(entry_out[p])
    ) else $error("map lookup on port %0d returned a duplicate bank", p);
  end

endmodule

// File: remap/remap_ctrl.sv
module remap_ctrl (
  input  logic                     clk,
  input  logic                     rst,
  input  bmm_cfg_pkg::vreq_t       due_req,
  input  bmm_map_pkg::map_entry_t  wr_entry,
  input  bmm_map_pkg::map_entry_t  rd_entry,
  output bmm_map_pkg::map_wr_t     upd,
  output bmm_cfg_pkg::pcmd_t       rd_cmd,
  output bmm_cfg_pkg::pcmd_t       wr_cmd,
  output bmm_cfg_pkg::data_t       wr_data,
  output logic                     ready
);

  import bmm_cfg_pkg::*;
  import bmm_map_pkg::*;

  ctrl_state_e state;
  row_t        init_row;
  map_entry_t  ident;
  map_entry_t  swapped;
  pbank_t      rd_pb;
  pbank_t      wr_pb;
  pbank_t      wr_free;
  logic        conflict;

  // ##########################################################################
  // init sweep and ready
  // ##########################################################################
  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= ST_INIT;
      init_row <= '0;
      ready    <= 1'b0;
    end else begin
      ready <= (state == ST_RUN);
      if (state == ST_INIT) begin
        init_row <= init_row + 1'b1;
        if (init_row == row_t'(ROWS - 1)) begin
          state <= ST_RUN;  // last row written this cycle
        end
      end
    end
  end

  always_comb begin
    for (int v = 0; v < NUM_PBANKS; v++) begin
      ident[v] = pbank_t'(v);  // spare bank starts as free
    end
  end

  // ##########################################################################
  // translation and conflict remap
  // ##########################################################################
  assign rd_pb    = rd_entry[due_req.rd_addr.bank];
  assign wr_pb    = wr_entry[due_req.wr_addr.bank];
  assign wr_free  = wr_entry[FREE_IDX];
  assign conflict = due_req.read && due_req.write && (rd_pb == wr_pb);

  // written vbank takes the free bank, its old bank becomes free
  always_comb begin
    swapped                        = wr_entry;
    swapped[due_req.wr_addr.bank] = wr_free;
    swapped[FREE_IDX]             = wr_pb;
  end

  always_comb begin
    if (state == ST_INIT) begin
      upd.en    = 1'b1;
      upd.row   = init_row;
      upd.entry = ident;
    end else begin
      upd.en    = conflict;
      upd.row   = due_req.wr_addr.row;
      upd.entry = swapped;
    end
  end

  assign rd_cmd.en   = due_req.read;
  assign rd_cmd.bank = rd_pb;
  assign rd_cmd.row  = due_req.rd_addr.row;

  assign wr_cmd.en   = due_req.write;
  assign wr_cmd.bank = conflict ? wr_free : wr_pb;  // steer around the read
  assign wr_cmd.row  = due_req.wr_addr.row;

  assign wr_data = due_req.wr_data;

  // ##########################################################################
  // checks
  // ##########################################################################
  a_no_bank_clash: assert property (
    @(posedge clk) disable iff (rst)
    (rd_cmd.en && wr_cmd.en) |-> (rd_cmd.bank != wr_cmd.bank)
  ) else $error("read and write sent to the same physical bank");

  a_quiet_in_init: assert property (
    @(posedge clk) disable iff (rst)
    (state == ST_INIT) |-> !(rd_cmd.en || wr_cmd.en)
  ) else $error("bank command issued during map init");

endmodule

// File: banks/phys_bank_array.sv
module phys_bank_array #(
  parameter int SRAM_DELAY = 2
) (
  input  logic               clk,
  input  bmm_cfg_pkg::pcmd_t rd_cmd,
  input  bmm_cfg_pkg::pcmd_t wr_cmd,
  input  bmm_cfg_pkg::data_t wr_data,
  output bmm_cfg_pkg::data_t rd_data
);

  import bmm_cfg_pkg::*;

  data_t [NUM_PBANKS-1:0] bank_q;
  pbank_t                 rd_bank_q;
  data_t                  sram_out;

  // ##########################################################################
  // one port per bank
  // ##########################################################################
  for (genvar b = 0; b < NUM_PBANKS; b++) begin : g_bank
    data_t mem [ROWS];
    data_t q;
    logic  wr_hit;
    logic  rd_hit;

    assign wr_hit = wr_cmd.en && (wr_cmd.bank == pbank_t'(b));
    assign rd_hit = rd_cmd.en && (rd_cmd.bank == pbank_t'(b));

    always_ff @(posedge clk) begin
      if (wr_hit) begin
        mem[wr_cmd.row] <= wr_data;
      end else if (rd_hit) begin
        q <= mem[rd_cmd.row];
      end
    end

    assign bank_q[b] = q;
  end

  always_ff @(posedge clk) begin
    rd_bank_q <= rd_cmd.bank;
  end

  assign sram_out = bank_q[rd_bank_q];  // one cycle after the command

  if (SRAM_DELAY == 1) begin : g_out_direct
    assign rd_data = sram_out;
  end else begin : g_out_pipe
    data_t opipe [SRAM_DELAY-1];

    always_ff @(posedge clk) begin
      opipe[0] <= sram_out;
      for (int i = 1; i < SRAM_DELAY - 1; i++) begin
        opipe[i] <= opipe[i-1];
      end
    end

    assign rd_data = opipe[SRAM_DELAY-2];
  end

  a_single_port: assert property (
    @(posedge clk) (rd_cmd.en && wr_cmd.en) |-> (rd_cmd.bank != wr_cmd.bank)
  ) else $error("bank %0d got a read and a write in one cycle", wr_cmd.bank);

endmodule

// File: design/bmm_top.sv
module bmm_top #(
  parameter int SRAM_DELAY = 2,
  parameter int FLOPIN     = 0
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                wr_en,
  input  bmm_cfg_pkg::vaddr_t wr_addr,
  input  bmm_cfg_pkg::data_t  wr_data,
  input  logic                rd_en,
  input  bmm_cfg_pkg::vaddr_t rd_addr,
  output bmm_cfg_pkg::data_t  rd_data,
  output logic                ready
);

  import bmm_cfg_pkg::*;
  import bmm_map_pkg::*;

  vreq_t      now_req;
  vreq_t      due_req;
  map_entry_t wr_entry;
  map_entry_t rd_entry;
  map_wr_t    upd;
  pcmd_t      rd_cmd;
  pcmd_t      wr_cmd;
  data_t      bank_wr_data;

  req_pipe #(
    .SRAM_DELAY (SRAM_DELAY),
    .FLOPIN     (FLOPIN)
  ) u_req_pipe (
    .clk     (clk),
    .rst     (rst),
    .ready   (ready),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .rd_en   (rd_en),
    .rd_addr (rd_addr),
    .now_req (now_req),
    .due_req (due_req)
  );

  map_table #(
    .SRAM_DELAY (SRAM_DELAY)
  ) u_map_table (
    .clk       (clk),
    .rst       (rst),
    .wr_row    (now_req.wr_addr.row),
    .rd_row    (now_req.rd_addr.row),
    .lookup_wr (now_req.write),
    .lookup_rd (now_req.read),
    .upd       (upd),
    .wr_entry  (wr_entry),
    .rd_entry  (rd_entry)
  );

  remap_ctrl u_remap_ctrl (
    .clk      (clk),
    .rst      (rst),
    .due_req  (due_req),
    .wr_entry (wr_entry),
    .rd_entry (rd_entry),
    .upd      (upd),
    .rd_cmd   (rd_cmd),
    .wr_cmd   (wr_cmd),
    .wr_data  (bank_wr_data),
    .ready    (ready)
  );

  phys_bank_array #(
    .SRAM_DELAY (SRAM_DELAY)
  ) u_phys_bank_array (
    .clk     (clk),
    .rd_cmd  (rd_cmd),
    .wr_cmd  (wr_cmd),
    .wr_data (bank_wr_data),
    .rd_data (rd_data)
  );

endmodule

// File: verif/bmm_tb_checks.svh
`ifndef BMM_TB_CHECKS_SVH
`define BMM_TB_CHECKS_SVH

int err_cnt   = 0;
int check_cnt = 0;

// ##########################################################################
// compare tasks
// ##########################################################################
task automatic check_data(input string name, input bmm_cfg_pkg::data_t exp,
                          input bmm_cfg_pkg::data_t got);
  check_cnt++;
  if (got !== exp) begin
    err_cnt++;
    $display("[ERROR] t=%0t %s expected %h got %h", $time, name, exp, got);
  end
endtask

task automatic check_bit(input string name, input logic exp, input logic got);
  check_cnt++;
  if (got !== exp) begin
    err_cnt++;
    $display("[ERROR] t=%0t %s expected %b got %b", $time, name, exp, got);
  end
endtask

// one line per finished test
task automatic report_test(input string name, input int err_before);
  int n;
  n = err_cnt - err_before;
  if (n == 0) begin
    $display("test %s: done, no errors", name);
  end else begin
    $display("test %s: done, %0d errors", name, n);
  end
endtask

`endif

// File: verif/bmm_tb.sv
module bmm_tb;

  import bmm_cfg_pkg::*;

  localparam int SRAM_DELAY = 2;
  localparam int FLOPIN     = 0;
  localparam int L          = FLOPIN + 2 * SRAM_DELAY;  // read latency at the top
  localparam int NADDR      = NUM_VBANKS * ROWS;
  localparam int CONF_N     = 6 * ROWS;
  localparam int COLL_N     = 16;
  localparam int RAND_N     = 300;

  // cycle budget per test
  localparam int RESET_CYC = 8 + ROWS + 4;
  localparam int T_WRRD    = 2 * NADDR + L;
  localparam int T_GATE    = L + RESET_CYC + NADDR + L;
  localparam int T_CONF    = CONF_N + NADDR + L;
  localparam int T_COLL    = 3 * COLL_N + L;
  localparam int T_RAND    = RAND_N + L + NADDR + L;
  localparam int LIMIT     = RESET_CYC + T_WRRD + T_GATE + T_CONF + T_COLL + T_RAND
                             + ROWS + L + 50;

  typedef struct packed {
    logic  vld;
    data_t data;
  } exp_rd_t;

  logic    clk;
  logic    rst;
  logic    wr_en;
  vaddr_t  wr_addr;
  data_t   wr_data;
  logic    rd_en;
  vaddr_t  rd_addr;
  data_t   rd_data;
  logic    ready;

  data_t   ref_mem [NADDR];
  exp_rd_t pend [$];
  logic    ready_exp;
  integer  seed;
  int      cycle_cnt = 0;

  `include "bmm_tb_checks.svh"

  bmm_top #(
    .SRAM_DELAY (SRAM_DELAY),
    .FLOPIN     (FLOPIN)
  ) uut (
    .clk     (clk),
    .rst     (rst),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .rd_en   (rd_en),
    .rd_addr (rd_addr),
    .rd_data (rd_data),
    .ready   (ready)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  function automatic vaddr_t rand_addr();
    logic [31:0] r;
    r = $random(seed);
    return vaddr_t'(r[$bits(vaddr_t)-1:0]);
  endfunction

  function automatic data_t rand_data();
    return data_t'($random(seed));
  endfunction

  // ##########################################################################
  // one clock of stimulus, expected reads retire L cycles later
  // ##########################################################################
  task automatic cycle(input logic we, input vaddr_t wa, input data_t wd,
                       input logic re, input vaddr_t ra);
    exp_rd_t e;
    @(negedge clk);
    if (pend.size() == L) begin
      e = pend.pop_front();
      if (e.vld) begin
        check_data("rd_data", e.data, rd_data);
      end
    end
    check_bit("ready", ready_exp, ready);
    wr_en   = we;
    wr_addr = wa;
    wr_data = wd;
    rd_en   = re;
    rd_addr = ra;
    e.vld   = re && ready_exp;
    e.data  = ref_mem[ra];  // old value on same-address collision
    pend.push_back(e);
    if (we && ready_exp) begin
      ref_mem[wa] = wd;
    end
  endtask

  task automatic idle(input int n);
    repeat (n) cycle(1'b0, '0, '0, 1'b0, '0);
  endtask

  task automatic read_all();
    for (int i = 0; i < NADDR; i++) begin
      cycle(1'b0, '0, '0, 1'b1, vaddr_t'(i));
    end
    idle(L);
  endtask

  // requests while ready is low must be dropped
  task automatic apply_reset();
    ready_exp = 1'b0;
    rst       = 1'b1;
    idle(8);
    rst = 1'b0;
    repeat (ROWS) begin
      cycle(1'b1, rand_addr(), rand_data(), 1'b1, rand_addr());
    end
    ready_exp = 1'b1;
  endtask

  // ##########################################################################
  // directed tests
  // ##########################################################################
  task automatic write_then_read();
    int err0;
    err0 = err_cnt;
    for (int i = 0; i < NADDR; i++) begin
      cycle(1'b1, vaddr_t'(i), rand_data(), 1'b0, '0);
    end
    read_all();
    report_test("write then read", err0);
  endtask

  task automatic reset_gating();
    int err0;
    err0 = err_cnt;
    idle(L);
    apply_reset();
    read_all();
    report_test("ready after reset", err0);
  endtask

  task automatic conflict_remap();
    int     err0;
    vaddr_t ra;
    vaddr_t wa;
    err0 = err_cnt;
    for (int i = 0; i < CONF_N; i++) begin
      ra      = rand_addr();
      wa.bank = ra.bank;
      wa.row  = ra.row + row_t'(1 + (i % (ROWS - 1)));  // never the read row
      cycle(1'b1, wa, rand_data(), 1'b1, ra);
    end
    read_all();
    report_test("conflict remap", err0);
  endtask

  task automatic same_addr_collision();
    int     err0;
    vaddr_t a;
    err0 = err_cnt;
    for (int i = 0; i < COLL_N; i++) begin
      a = rand_addr();
      cycle(1'b1, a, rand_data(), 1'b1, a);
      cycle(1'b0, '0, '0, 1'b1, a);
      idle(1);
    end
    idle(L);
    report_test("same-address collision", err0);
  endtask

  task automatic random_traffic();
    int     err0;
    vaddr_t ra;
    vaddr_t wa;
    err0 = err_cnt;
    for (int i = 0; i < RAND_N; i++) begin
      wa = rand_addr();
      ra = rand_addr();
      if (i < RAND_N / 2) begin
        wa.row = wa.row & row_t'(3);  // few rows, more map forwarding
        ra.row = ra.row & row_t'(3);
      end
      cycle(1'b1, wa, rand_data(), 1'b1, ra);
    end
    idle(L);
    read_all();
    report_test("random traffic", err0);
  endtask

  initial begin
    seed      = 32'hf3e1_961b;
    rst       = 1'b1;
    wr_en     = 1'b0;
    wr_addr   = '0;
    wr_data   = '0;
    rd_en     = 1'b0;
    rd_addr   = '0;
    ready_exp = 1'b0;
    apply_reset();
    write_then_read();
    reset_gating();
    conflict_remap();
    same_addr_collision();
    random_traffic();
    $display("checks %0d, errors %0d, cycles %0d", check_cnt, err_cnt, cycle_cnt);
    if (err_cnt == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    while (cycle_cnt < LIMIT) begin
      @(posedge clk);
    end
    $display("timeout after %0d cycles, the tests did not finish", cycle_cnt);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

// File: bmm_top.f
+incdir+verif
common/bmm_cfg_pkg.sv
common/bmm_map_pkg.sv
design/req_pipe.sv
remap/map_table.sv
remap/remap_ctrl.sv
banks/phys_bank_array.sv
design/bmm_top.sv
verif/bmm_tb.sv

// File: Makefile
VERILATOR  ?= verilator
FILELIST   := bmm_top.f
TB_TOP     := bmm_tb
RTL_TOP    := bmm_top
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing --assert -Wno-fatal -j 0
PASS_MSG   := TEST RESULT: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
